//--- flist.f
+incdir+design
design/riscv_pkg.sv
design/maindec.sv
design/aludec.sv
design/extend.sv
design/regfile.sv
design/id_stage.sv
design/id_ex_reg.sv
design/decode_top.sv
verif/tb_clkgen.sv
verif/decode_sva.sv
verif/decode_tb.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module decode_tb \
  -o decode_sim && ./obj_dir/decode_sim 2>&1 | tee sim.log
grep -q "^RESULT: PASS$" sim.log && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}

//--- verif/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_settings.svh"

module decode_tb import riscv_pkg::*;;

  logic             clk;
  logic             rst_n;
  logic             insn_valid;
  logic [`XLEN-1:0] insn;
  logic [`XLEN-1:0] pc;
  logic             wb_we;
  logic [4:0]       wb_rd_addr;
  logic [`XLEN-1:0] wb_rd_wdata;
  logic             flush;
  ex_bundle_t       ex;

  logic [31:0] seed = 32'h53beee74;
  logic [`XLEN-1:0] mregs [0:`NUM_REGS-1];
  ex_bundle_t  exp_q [$];
  int          due_q [$];
  ex_bundle_t  exp_e;
  int          cyc;
  int          errors;
  int          checks;

  tb_clkgen u_clkgen (.clk(clk));

  decode_top decode_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .insn_valid (insn_valid),
    .insn       (insn),
    .pc         (pc),
    .wb_we      (wb_we),
    .wb_rd_addr (wb_rd_addr),
    .wb_rd_wdata(wb_rd_wdata),
    .flush      (flush),
    .ex         (ex)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // funct3 table shared by OP and OP-IMM
  function automatic alu_ctrl_e funct_alu(input logic [2:0] f3, input logic sub,
                                          input logic sra);
    case (f3)
      3'd0:    return sub ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return sra ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic logic [31:0] read_src(input logic [4:0] a, input logic we,
                                           input logic [4:0] wrd, input logic [31:0] wd);
    if (a == 5'd0) begin
      return 32'h0;
    end
    return (we && (wrd == a)) ? wd : mregs[a];
  endfunction

  function automatic ex_bundle_t ref_decode(input logic [31:0] w, input logic [31:0] pc_v,
                                            input logic we, input logic [4:0] wrd,
                                            input logic [31:0] wd, input logic fl);
    ex_bundle_t e;
    logic [2:0] f3;
    logic       rd_w;
    logic       mem_w;
    logic       ill;
    logic       ec;
    logic       eb;
    e = '0;
    f3 = w[14:12];
    rd_w = 1'b0;
    mem_w = 1'b0;
    ill = 1'b0;
    ec = 1'b0;
    eb = 1'b0;
    e.valid = 1'b1;
    e.pc = pc_v;
    e.rd_addr = w[11:7];
    e.csr_addr = w[31:20];
    e.imm = {{20{w[31]}}, w[31:20]};
    case (w[6:0])
      OPC_LUI, OPC_AUIPC: begin
        rd_w = 1'b1;
        e.ctrl.alu_a_sel = (w[6:0] == OPC_LUI) ? ALU_A_ZERO : ALU_A_PC;
        e.ctrl.alu_b_sel = ALU_B_IMM;
        e.ctrl.alu_ctrl = (w[6:0] == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
        e.imm = {w[31:12], 12'd0};
      end
      OPC_JAL: begin
        rd_w = 1'b1;
        e.ctrl.is_jal = 1'b1;
        e.ctrl.alu_a_sel = ALU_A_PC;
        e.ctrl.alu_b_sel = ALU_B_IMM;
        e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      OPC_JALR: begin
        rd_w = 1'b1;
        e.ctrl.is_jalr = 1'b1;
        e.ctrl.is_rs1_read = 1'b1;
        e.ctrl.alu_b_sel = ALU_B_IMM;
        ill = (f3 != 3'd0);
      end
      OPC_BRANCH: begin
        e.ctrl.is_branch = 1'b1;
        e.ctrl.is_rs1_read = 1'b1;
        e.ctrl.is_rs2_read = 1'b1;
        e.ctrl.alu_ctrl = ALU_SUB;
        e.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        ill = (f3 == 3'd2) || (f3 == 3'd3);
      end
      OPC_LOAD: begin
        rd_w = 1'b1;
        e.ctrl.is_mem_read = 1'b1;
        e.ctrl.mem_size = f3;
        e.ctrl.is_rs1_read = 1'b1;
        e.ctrl.alu_b_sel = ALU_B_IMM;
        ill = (f3 == 3'd3) || (f3 >= 3'd6);
      end
      OPC_STORE: begin
        mem_w = 1'b1;
        e.ctrl.mem_size = f3;
        e.ctrl.is_rs1_read = 1'b1;
        e.ctrl.is_rs2_read = 1'b1;
        e.ctrl.alu_b_sel = ALU_B_IMM;
        e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        ill = (f3 > 3'd2);
      end
      OPC_OP_IMM: begin
        rd_w = 1'b1;
        e.ctrl.is_rs1_read = 1'b1;
        e.ctrl.alu_b_sel = ALU_B_IMM;
        e.ctrl.alu_ctrl = funct_alu(f3, 1'b0, w[30]);
      end
      OPC_OP: begin
        rd_w = 1'b1;
        e.ctrl.is_rs1_read = 1'b1;
        e.ctrl.is_rs2_read = 1'b1;
        e.ctrl.alu_ctrl = funct_alu(f3, w[30], w[30]);
      end
      OPC_SYSTEM: begin
        if (f3 == 3'd0) begin
          ec = (w[31:20] == 12'h000);
          eb = (w[31:20] == 12'h001);
          ill = !ec && !eb;
        end else if (f3 == 3'd4) begin
          ill = 1'b1;
        end else begin
          rd_w = 1'b1;
          e.ctrl.csr_op = f3[1:0];
          e.ctrl.is_csr_read = !((f3[1:0] == 2'b01) && (w[11:7] == 5'd0));
          e.ctrl.is_csr_write = (f3[1:0] == 2'b01) || (w[19:15] != 5'd0);
          e.ctrl.is_rs1_read = !f3[2];
        end
      end
      default: ill = 1'b1;
    endcase
    e.rs1_addr = e.ctrl.is_rs1_read ? w[19:15] : 5'd0;
    e.rs2_addr = e.ctrl.is_rs2_read ? w[24:20] : 5'd0;
    e.rs1_data = read_src(e.rs1_addr, we, wrd, wd);
    e.rs2_data = read_src(e.rs2_addr, we, wrd, wd);
    e.trap_valid = ec || eb || ill;
    e.ctrl.is_rd_write = rd_w && (w[11:7] != 5'd0) && !e.trap_valid;
    e.ctrl.is_mem_write = mem_w && !e.trap_valid;
    if (ec) begin
      e.trap_cause = 5'(`TRAP_ECALL_M);
    end else if (eb) begin
      e.trap_cause = 5'(`TRAP_BREAKPOINT);
    end else if (ill) begin
      e.trap_cause = 5'(`TRAP_ILLEGAL);
    end
    if (fl) begin
      e.valid = 1'b0;
      e.trap_valid = 1'b0;
    end
    return e;
  endfunction

  function automatic logic [6:0] ctl_opcode(input logic [31:0] r);
    case (r % 7)
      0:       return OPC_LOAD;
      1:       return OPC_STORE;
      2:       return OPC_BRANCH;
      3:       return OPC_JAL;
      4:       return OPC_JALR;
      5:       return OPC_LUI;
      default: return OPC_AUIPC;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // inputs change 1 ns after the edge, expectation due at the next edge
  task automatic drive(input logic v, input logic [31:0] w, input logic [31:0] pc_v,
                       input logic we, input logic [4:0] wrd, input logic [31:0] wd,
                       input logic fl);
    @(posedge clk);
    #1;
    insn_valid = v;
    insn = w;
    pc = pc_v;
    wb_we = we;
    wb_rd_addr = wrd;
    wb_rd_wdata = wd;
    flush = fl;
    if (v) begin
      exp_q.push_back(ref_decode(w, pc_v, we, wrd, wd, fl));
      due_q.push_back(cyc + 1);
    end
    if (we && (wrd != 5'd0)) begin
      mregs[wrd] = wd;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    int n;
    drive(1'b0, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0, 1'b0);
    n = 0;
    while ((exp_q.size() > 0) && (n < 20)) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() > 0) begin
      $display("timeout in %s: %0d expected outputs never compared", name, exp_q.size());
      $display("RESULT: FAIL");
      $finish;
    end else begin
      $display("test %s done, %0d errors", name, errors - err_start);
    end
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // compare at the falling edge, where ex is stable
  always @(negedge clk) begin
    if ((exp_q.size() > 0) && (due_q[0] == cyc)) begin
      exp_e = exp_q.pop_front();
      void'(due_q.pop_front());
      compare_value("ex.valid", 32'(ex.valid), 32'(exp_e.valid));
      compare_value("ex.trap_valid", 32'(ex.trap_valid), 32'(exp_e.trap_valid));
      compare_value("ex.trap_cause", 32'(ex.trap_cause), 32'(exp_e.trap_cause));
      compare_value("ex.pc", ex.pc, exp_e.pc);
      compare_value("ex.rs1_addr", 32'(ex.rs1_addr), 32'(exp_e.rs1_addr));
      compare_value("ex.rs2_addr", 32'(ex.rs2_addr), 32'(exp_e.rs2_addr));
      compare_value("ex.rd_addr", 32'(ex.rd_addr), 32'(exp_e.rd_addr));
      compare_value("ex.rs1_data", ex.rs1_data, exp_e.rs1_data);
      compare_value("ex.rs2_data", ex.rs2_data, exp_e.rs2_data);
      compare_value("ex.imm", ex.imm, exp_e.imm);
      compare_value("ex.csr_addr", 32'(ex.csr_addr), 32'(exp_e.csr_addr));
      compare_value("ex.ctrl.alu_ctrl", 32'(ex.ctrl.alu_ctrl), 32'(exp_e.ctrl.alu_ctrl));
      compare_value("ex.ctrl.is_rd_write", 32'(ex.ctrl.is_rd_write),
                    32'(exp_e.ctrl.is_rd_write));
      compare_value("ex.ctrl", 32'(ex.ctrl), 32'(exp_e.ctrl));
    end else if (rst_n) begin
      // no strobe sampled at the last edge
      compare_value("ex.valid", 32'(ex.valid), 32'h0);
    end
  end

  initial begin : main
    logic [31:0] r;
    logic [31:0] w;
    int          err_start;
    rst_n = 1'b0;
    insn_valid = 1'b0;
    insn = 32'h0;
    pc = 32'h0;
    wb_we = 1'b0;
    wb_rd_addr = 5'd0;
    wb_rd_wdata = 32'h0;
    flush = 1'b0;
    errors = 0;
    checks = 0;
    for (int k = 0; k < `NUM_REGS; k++) begin
      mregs[k] = 32'h0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    err_start = errors;
    @(negedge clk);
    compare_value("ex.valid", 32'(ex.valid), 32'h0);
    compare_value("ex.trap_valid", 32'(ex.trap_valid), 32'h0);
    drive(1'b1, {7'h00, 5'd2, 5'd1, 3'd0, 5'd4, OPC_OP}, 32'h100, 1'b0, 5'd0, 32'h0, 1'b1);
    drive(1'b1, 32'h00000073, 32'h104, 1'b0, 5'd0, 32'h0, 1'b1);
    finish_test("reset_flush", err_start);

    // load x1..x31 through the writeback port
    for (int k = 1; k < `NUM_REGS; k++) begin
      drive(1'b0, 32'h0, 32'h0, 1'b1, 5'(k), next_rand(), 1'b0);
    end
    err_start = errors;
    for (int n = 0; n < 40; n++) begin
      r = next_rand();
      w = next_rand();
      w[6:0] = r[0] ? OPC_OP : OPC_OP_IMM;
      if (r[0]) begin
        w[31:25] = r[1] ? 7'h20 : 7'h00;
      end
      drive(1'b1, w, {r[31:2], 2'b00}, 1'b0, 5'd0, 32'h0, 1'b0);
    end
    finish_test("alu_decode", err_start);

    err_start = errors;
    for (int n = 0; n < 40; n++) begin
      r = next_rand();
      w = next_rand();
      w[6:0] = ctl_opcode(r);
      drive(1'b1, w, {r[31:2], 2'b00}, 1'b0, 5'd0, 32'h0, 1'b0);
    end
    finish_test("imm_classes", err_start);

    err_start = errors;
    drive(1'b1, {7'h00, 5'd3, 5'd4, 3'd0, 5'd0, OPC_OP}, 32'h200, 1'b0, 5'd0, 32'h0, 1'b0);
    r = next_rand();
    drive(1'b1, {r[31:7], OPC_LUI}, 32'h204, 1'b0, 5'd0, 32'h0, 1'b0);
    r = next_rand();
    drive(1'b1, {r[31:7], OPC_JAL}, 32'h208, 1'b0, 5'd0, 32'h0, 1'b0);
    drive(1'b1, {12'h7ff, 5'd9, 3'd0, 5'd0, OPC_OP_IMM}, 32'h20c, 1'b0, 5'd0, 32'h0, 1'b0);
    finish_test("x0_unused", err_start);

    err_start = errors;
    w = {7'h00, 5'd7, 5'd3, 3'd0, 5'd9, OPC_OP};
    drive(1'b1, w, 32'h300, 1'b1, 5'd3, next_rand(), 1'b0);
    drive(1'b1, w, 32'h304, 1'b0, 5'd0, 32'h0, 1'b0);
    drive(1'b1, w, 32'h308, 1'b1, 5'd7, next_rand(), 1'b0);
    drive(1'b1, w, 32'h30c, 1'b0, 5'd0, 32'h0, 1'b0);
    // a write to x0 never reaches a source
    drive(1'b1, {7'h00, 5'd0, 5'd0, 3'd0, 5'd1, OPC_OP}, 32'h310, 1'b1, 5'd0, 32'hdeadbeef,
          1'b0);
    finish_test("wb_bypass", err_start);

    err_start = errors;
    drive(1'b1, 32'h00000073, 32'h400, 1'b0, 5'd0, 32'h0, 1'b0);
    drive(1'b1, 32'h00100073, 32'h404, 1'b0, 5'd0, 32'h0, 1'b0);
    r = next_rand();
    drive(1'b1, {r[31:7], 7'b0001011}, 32'h408, 1'b0, 5'd0, 32'h0, 1'b0);
    drive(1'b1, {12'h010, 5'd1, 3'd3, 5'd2, OPC_LOAD}, 32'h40c, 1'b0, 5'd0, 32'h0, 1'b0);
    drive(1'b1, {7'h00, 5'd2, 5'd1, 3'd7, 5'd4, OPC_STORE}, 32'h410, 1'b0, 5'd0, 32'h0,
          1'b0);
    finish_test("traps", err_start);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/decode_sva.sv
`timescale 1ns/1ps
`default_nettype none

module decode_sva import riscv_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       flush,
  input ex_bundle_t ex
);

  // nothing leaves decode while reset is held
  assert property (@(posedge clk) !rst_n |-> !ex.valid)
    else $error("ex.valid high during reset");

  assert property (@(posedge clk) disable iff (!rst_n) ex.trap_valid |-> ex.valid)
    else $error("trap_valid without valid");

  // flushed slot is empty one cycle later
  assert property (@(posedge clk) disable iff (!rst_n) flush |=> !ex.valid)
    else $error("ex.valid high after flush");

endmodule

bind decode_top decode_sva decode_sva_inst (
  .clk  (clk),
  .rst_n(rst_n),
  .flush(flush),
  .ex   (ex)
);

`default_nettype wire

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int HALF_PERIOD = 2
) (
  output logic clk
);

  initial clk = 1'b0;

  // 4 ns period
  always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

//--- design/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_settings.svh"

module decode_top import riscv_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             insn_valid,
  input  logic [`XLEN-1:0] insn,
  input  logic [`XLEN-1:0] pc,
  input  logic             wb_we,
  input  logic [4:0]       wb_rd_addr,
  input  logic [`XLEN-1:0] wb_rd_wdata,
  input  logic             flush,
  output ex_bundle_t       ex
);

  logic [4:0]       rs1_addr;
  logic [4:0]       rs2_addr;
  logic [`XLEN-1:0] rs1_rdata;
  logic [`XLEN-1:0] rs2_rdata;
  ex_bundle_t       id_bundle;

  regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_rdata(rs1_rdata),
    .rs2_rdata(rs2_rdata),
    .we       (wb_we),
    .rd_addr  (wb_rd_addr),
    .rd_wdata (wb_rd_wdata)
  );

  id_stage u_id_stage (
    .insn_valid (insn_valid),
    .insn       (insn),
    .pc         (pc),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_rdata  (rs1_rdata),
    .rs2_rdata  (rs2_rdata),
    .wb_we      (wb_we),
    .wb_rd_addr (wb_rd_addr),
    .wb_rd_wdata(wb_rd_wdata),
    .id_bundle  (id_bundle)
  );

  id_ex_reg u_id_ex_reg (
    .clk  (clk),
    .rst_n(rst_n),
    .flush(flush),
    .d    (id_bundle),
    .q    (ex)
  );

endmodule

`default_nettype wire

//--- design/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg import riscv_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush,
  input  ex_bundle_t d,
  output ex_bundle_t q
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else begin
      q <= d;
      // a flushed slot must not raise a trap in execute
      if (flush) begin
        q.valid      <= 1'b0;
        q.trap_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_settings.svh"

module id_stage import riscv_pkg::*; (
  input  logic             insn_valid,
  input  insn_u            insn,
  input  logic [`XLEN-1:0] pc,
  output logic [4:0]       rs1_addr,
  output logic [4:0]       rs2_addr,
  input  logic [`XLEN-1:0] rs1_rdata,
  input  logic [`XLEN-1:0] rs2_rdata,
  input  logic             wb_we,
  input  logic [4:0]       wb_rd_addr,
  input  logic [`XLEN-1:0] wb_rd_wdata,
  output ex_bundle_t       id_bundle
);

  decode_flags_t    flags;
  alu_ctrl_e        alu_ctrl;
  logic [`XLEN-1:0] imm;
  logic             fwd_rs1;
  logic             fwd_rs2;
  logic             trap;

  maindec u_maindec (
    .insn (insn),
    .flags(flags)
  );

  aludec u_aludec (
    .insn    (insn),
    .alu_op  (flags.alu_op),
    .alu_ctrl(alu_ctrl)
  );

  extend u_extend (
    .insn  (insn),
    .imm_op(flags.imm_op),
    .imm   (imm)
  );

  // unread sources go to x0
  assign rs1_addr = flags.is_rs1_read ? insn.r.rs1 : 5'd0;
  assign rs2_addr = flags.is_rs2_read ? insn.r.rs2 : 5'd0;

  // writeback lands this cycle, take it before the register file has it
  assign fwd_rs1 = wb_we && (rs1_addr != 5'd0) && (rs1_addr == wb_rd_addr);
  assign fwd_rs2 = wb_we && (rs2_addr != 5'd0) && (rs2_addr == wb_rd_addr);

  assign trap = flags.ecall || flags.ebreak || flags.illegal;

  always_comb begin
    id_bundle          = '0;
    id_bundle.valid    = insn_valid;
    id_bundle.pc       = pc;
    id_bundle.rs1_addr = rs1_addr;
    id_bundle.rs2_addr = rs2_addr;
    id_bundle.rd_addr  = insn.r.rd;
    id_bundle.rs1_data = fwd_rs1 ? wb_rd_wdata : rs1_rdata;
    id_bundle.rs2_data = fwd_rs2 ? wb_rd_wdata : rs2_rdata;
    id_bundle.imm      = imm;
    id_bundle.csr_addr = insn.i.imm;

    id_bundle.ctrl.is_branch    = flags.is_branch;
    id_bundle.ctrl.is_jal       = flags.is_jal;
    id_bundle.ctrl.is_jalr      = flags.is_jalr;
    id_bundle.ctrl.is_mem_read  = flags.is_mem_read;
    id_bundle.ctrl.is_mem_write = flags.is_mem_write && !trap;
    id_bundle.ctrl.mem_size     = flags.mem_size;
    id_bundle.ctrl.is_csr_read  = flags.is_csr_read;
    id_bundle.ctrl.is_csr_write = flags.is_csr_write;
    id_bundle.ctrl.csr_op       = flags.csr_op;
    id_bundle.ctrl.is_rd_write  = flags.is_rd_write && (insn.r.rd != 5'd0) && !trap;
    id_bundle.ctrl.is_rs1_read  = flags.is_rs1_read;
    id_bundle.ctrl.is_rs2_read  = flags.is_rs2_read;
    id_bundle.ctrl.alu_ctrl     = alu_ctrl;
    id_bundle.ctrl.alu_a_sel    = flags.alu_a_sel;
    id_bundle.ctrl.alu_b_sel    = flags.alu_b_sel;

    // ecall over ebreak over illegal
    id_bundle.trap_valid = insn_valid && trap;
    if (!id_bundle.trap_valid) begin
      id_bundle.trap_cause = 5'd0;
    end else if (flags.ecall) begin
      id_bundle.trap_cause = 5'(`TRAP_ECALL_M);
    end else if (flags.ebreak) begin
      id_bundle.trap_cause = 5'(`TRAP_BREAKPOINT);
    end else begin
      id_bundle.trap_cause = 5'(`TRAP_ILLEGAL);
    end
  end

endmodule

`default_nettype wire

//--- design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_settings.svh"

module regfile (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [4:0]       rs1_addr,
  input  logic [4:0]       rs2_addr,
  output logic [`XLEN-1:0] rs1_rdata,
  output logic [`XLEN-1:0] rs2_rdata,
  input  logic             we,
  input  logic [4:0]       rd_addr,
  input  logic [`XLEN-1:0] rd_wdata
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd_addr != 5'd0)) begin
      regs[rd_addr] <= rd_wdata;
    end
  end

  assign rs1_rdata = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_rdata = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- design/extend.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_settings.svh"

module extend import riscv_pkg::*; (
  input  insn_u            insn,
  input  imm_op_e          imm_op,
  output logic [`XLEN-1:0] imm
);

  always_comb begin
    case (imm_op)
      IMM_S: imm = {{(`XLEN-12){insn.s.imm11_5[6]}}, insn.s.imm11_5, insn.s.imm4_0};
      IMM_B: imm = {{(`XLEN-12){insn.b.imm12}}, insn.b.imm11, insn.b.imm10_5,
                    insn.b.imm4_1, 1'b0};
      // upper 20 bits in place, low bits zero
      IMM_U: imm = {insn.u.imm31_12, 12'd0};
      IMM_J: imm = {{(`XLEN-20){insn.j.imm20}}, insn.j.imm19_12, insn.j.imm11,
                    insn.j.imm10_1, 1'b0};
      default: imm = {{(`XLEN-12){insn.i.imm[11]}}, insn.i.imm};
    endcase
  end

endmodule

`default_nettype wire

//--- design/aludec.sv
`timescale 1ns/1ps
`default_nettype none

module aludec import riscv_pkg::*; (
  input  insn_u     insn,
  input  alu_op_e   alu_op,
  output alu_ctrl_e alu_ctrl
);

  logic alt;
  logic is_reg_op;

  assign alt       = insn.r.funct7[5];
  assign is_reg_op = (insn.r.opcode == OPC_OP);

  always_comb begin
    case (alu_op)
      // lui passes the immediate straight through
      ALU_OP_ADD:    alu_ctrl = (insn.r.opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
      ALU_OP_BRANCH: alu_ctrl = ALU_SUB;
      ALU_OP_FUNCT: begin
        case (insn.r.funct3)
          3'b000:  alu_ctrl = (is_reg_op && alt) ? ALU_SUB : ALU_ADD;
          3'b001:  alu_ctrl = ALU_SLL;
          3'b010:  alu_ctrl = ALU_SLT;
          3'b011:  alu_ctrl = ALU_SLTU;
          3'b100:  alu_ctrl = ALU_XOR;
          // srai carries the same bit 30 as sra
          3'b101:  alu_ctrl = alt ? ALU_SRA : ALU_SRL;
          3'b110:  alu_ctrl = ALU_OR;
          default: alu_ctrl = ALU_AND;
        endcase
      end
      default: alu_ctrl = ALU_ADD;
    endcase
  end

endmodule

`default_nettype wire

//--- design/maindec.sv
`timescale 1ns/1ps
`default_nettype none

module maindec import riscv_pkg::*; (
  input  insn_u         insn,
  output decode_flags_t flags
);

  logic [2:0] funct3;

  assign funct3 = insn.r.funct3;

  always_comb begin
    flags           = '0;
    flags.alu_op    = ALU_OP_ADD;
    flags.alu_a_sel = ALU_A_RS1;
    flags.alu_b_sel = ALU_B_RS2;
    flags.imm_op    = IMM_I;
    case (insn.r.opcode)
      OPC_LUI: begin
        flags.is_rd_write = 1'b1;
        flags.alu_a_sel   = ALU_A_ZERO;
        flags.alu_b_sel   = ALU_B_IMM;
        flags.imm_op      = IMM_U;
      end
      OPC_AUIPC: begin
        flags.is_rd_write = 1'b1;
        flags.alu_a_sel   = ALU_A_PC;
        flags.alu_b_sel   = ALU_B_IMM;
        flags.imm_op      = IMM_U;
      end
      OPC_JAL: begin
        flags.is_jal      = 1'b1;
        flags.is_rd_write = 1'b1;
        flags.alu_a_sel   = ALU_A_PC;
        flags.alu_b_sel   = ALU_B_IMM;
        flags.imm_op      = IMM_J;
      end
      OPC_JALR: begin
        flags.is_jalr     = 1'b1;
        flags.is_rd_write = 1'b1;
        flags.is_rs1_read = 1'b1;
        flags.alu_b_sel   = ALU_B_IMM;
        flags.illegal     = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        flags.is_branch   = 1'b1;
        flags.is_rs1_read = 1'b1;
        flags.is_rs2_read = 1'b1;
        flags.alu_op      = ALU_OP_BRANCH;
        flags.imm_op      = IMM_B;
        // 010 and 011 are not branch encodings
        flags.illegal     = (funct3[2:1] == 2'b01);
      end
      OPC_LOAD: begin
        flags.is_mem_read = 1'b1;
        flags.mem_size    = funct3;
        flags.is_rd_write = 1'b1;
        flags.is_rs1_read = 1'b1;
        flags.alu_b_sel   = ALU_B_IMM;
        flags.illegal     = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      OPC_STORE: begin
        flags.is_mem_write = 1'b1;
        flags.mem_size     = funct3;
        flags.is_rs1_read  = 1'b1;
        flags.is_rs2_read  = 1'b1;
        flags.alu_b_sel    = ALU_B_IMM;
        flags.imm_op       = IMM_S;
        flags.illegal      = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OPC_OP_IMM: begin
        flags.is_rd_write = 1'b1;
        flags.is_rs1_read = 1'b1;
        flags.alu_op      = ALU_OP_FUNCT;
        flags.alu_b_sel   = ALU_B_IMM;
      end
      OPC_OP: begin
        flags.is_rd_write = 1'b1;
        flags.is_rs1_read = 1'b1;
        flags.is_rs2_read = 1'b1;
        flags.alu_op      = ALU_OP_FUNCT;
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          // ecall and ebreak differ only in funct12
          if (insn.i.imm == 12'h000) begin
            flags.ecall = 1'b1;
          end else if (insn.i.imm == 12'h001) begin
            flags.ebreak = 1'b1;
          end else begin
            flags.illegal = 1'b1;
          end
        end else if (funct3 == 3'b100) begin
          flags.illegal = 1'b1;
        end else begin
          flags.csr_op       = funct3[1:0];
          // csrrw with rd = x0 skips the read, set/clear with rs1 = x0 skips the write
          flags.is_csr_read  = (funct3[1:0] != 2'b01) || (insn.r.rd != 5'd0);
          flags.is_csr_write = (funct3[1:0] == 2'b01) || (insn.r.rs1 != 5'd0);
          flags.is_rd_write  = 1'b1;
          flags.is_rs1_read  = !funct3[2];
        end
      end
      default: begin
        flags.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/riscv_pkg.sv
`default_nettype none

`include "riscv_settings.svh"

package riscv_pkg;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  // one instruction word, viewed per format
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } insn_u;

  typedef enum logic [1:0] {
    ALU_OP_ADD    = 2'd0,
    ALU_OP_BRANCH = 2'd1,
    ALU_OP_FUNCT  = 2'd2
  } alu_op_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_ctrl_e;

  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_op_e;

  typedef enum logic [1:0] {
    ALU_A_RS1  = 2'd0,
    ALU_A_PC   = 2'd1,
    ALU_A_ZERO = 2'd2
  } alu_a_sel_e;

  typedef enum logic {
    ALU_B_RS2 = 1'b0,
    ALU_B_IMM = 1'b1
  } alu_b_sel_e;

  typedef struct packed {
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       is_mem_read;
    logic       is_mem_write;
    // funct3 of the load or store
    logic [2:0] mem_size;
    logic       is_csr_read;
    logic       is_csr_write;
    // funct3[1:0]: 01 rw, 10 set, 11 clear
    logic [1:0] csr_op;
    logic       is_rd_write;
    logic       is_rs1_read;
    logic       is_rs2_read;
    alu_ctrl_e  alu_ctrl;
    alu_a_sel_e alu_a_sel;
    alu_b_sel_e alu_b_sel;
  } ctrl_t;

  typedef struct packed {
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       is_mem_read;
    logic       is_mem_write;
    logic [2:0] mem_size;
    logic       is_csr_read;
    logic       is_csr_write;
    logic [1:0] csr_op;
    logic       is_rd_write;
    logic       is_rs1_read;
    logic       is_rs2_read;
    alu_op_e    alu_op;
    alu_a_sel_e alu_a_sel;
    alu_b_sel_e alu_b_sel;
    imm_op_e    imm_op;
    logic       ecall;
    logic       ebreak;
    logic       illegal;
  } decode_flags_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [4:0]       rd_addr;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm;
    logic [11:0]      csr_addr;
    ctrl_t            ctrl;
    logic             trap_valid;
    logic [4:0]       trap_cause;
  } ex_bundle_t;

endpackage

`default_nettype wire

//--- design/riscv_settings.svh
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// datapath width and architectural register count
`define XLEN 32
`define NUM_REGS 32

// machine trap cause codes
`define TRAP_ECALL_M 11
`define TRAP_BREAKPOINT 3
`define TRAP_ILLEGAL 2

`endif
